//--- tb.f
+incdir+tests
rtl/mm_pkg.sv
rtl/ram_port_if.sv
rtl/tdp_ram.sv
rtl/mm_sequencer.sv
rtl/dot_accumulator.sv
rtl/mm_top.sv
tests/tb_mm_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the matrix-multiply testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_mm_top -f tb.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1
grep -q "^Test completed successfully$" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; cat sim.log 2>/dev/null; exit 1; }

//--- tests/tb_mm_model.svh
// Reference model for the matrix-multiply testbench
// One element of C from the testbench copies of A and B
`ifndef TB_MM_MODEL_SVH
`define TB_MM_MODEL_SVH

// Full-precision sum of A[row][k] * B[k][col], then cut to the output width
function automatic mm_pkg::acc_t ref_c(input int row, input int col);
    longint sum;
    sum = 0;
    for (int k = 0; k < mm_pkg::INNER; k++) begin
        sum += longint'(a_mat[row][k]) * longint'(b_mat[k][col]);  // Signed product
    end
    return mm_pkg::acc_t'(sum);  // Wraps like the 24-bit accumulator
endfunction

`endif

//--- tests/tb_mm_top.sv
// Matrix-multiply engine testbench with clock, reset, load and start,
// result checks against a reference model and a cycle timeout
`timescale 1ns/100ps
`default_nettype none

module tb_mm_top;

    localparam int PAIRS          = mm_pkg::ROWS_A / 2;
    localparam int RESULTS        = PAIRS * mm_pkg::COLS_B;  // out_valid pulses per run
    localparam int IDLE_CYCLES    = 20;   // Quiet time after done
    localparam int TIMEOUT_CYCLES = 400;  // Three runs of about 55 cycles each
    localparam int LOAD_WORDS     = (mm_pkg::IN_DEPTH > mm_pkg::W_DEPTH) ?
                                    mm_pkg::IN_DEPTH : mm_pkg::W_DEPTH;

    localparam mm_pkg::a_elem_t A_MIN = 8'sh80;  // -128
    localparam mm_pkg::b_elem_t B_MIN = 8'sh80;
    localparam mm_pkg::b_elem_t B_MAX = 8'sh7f;  // 127

    logic                         clk = 1'b0;
    logic                         rst_n;
    logic                         start;
    logic                         in_we;
    logic [mm_pkg::IN_ADDR_W-1:0] in_addr;
    mm_pkg::in_word_t             in_data;
    logic                         w_we;
    logic [mm_pkg::W_ADDR_W-1:0]  w_addr;
    mm_pkg::w_word_t              w_data;
    logic                         out_valid;
    mm_pkg::acc_t                 out_even;
    mm_pkg::acc_t                 out_odd;
    logic                         done;

    // Testbench copies of the loaded matrices
    mm_pkg::a_elem_t a_mat [mm_pkg::ROWS_A][mm_pkg::INNER];
    mm_pkg::b_elem_t b_mat [mm_pkg::INNER][mm_pkg::COLS_B];

    int seed = 32'h34;
    int n_valid;        // Pulses seen this run
    int exp_pair;
    int exp_col;
    int cycle_cnt = 0;

    `include "tb_mm_model.svh"

    mm_top DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .in_we    (in_we),
        .in_addr  (in_addr),
        .in_data  (in_data),
        .w_we     (w_we),
        .w_addr   (w_addr),
        .w_data   (w_data),
        .out_valid(out_valid),
        .out_even (out_even),
        .out_odd  (out_odd),
        .done     (done)
    );

    always #5 clk = ~clk;  // 10 ns period

    task automatic stop_on_error();
        $display("Test failed");
        $fatal(1, "Stopping at first error");
    endtask

    // Hang guard
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: runs did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_on_error();
        end
    end

    // Result checks on the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            n_valid  = 0;
            exp_pair = 0;
            exp_col  = 0;
        end else if (out_valid) begin
            assert (n_valid < RESULTS) else begin
                $display("Extra out_valid pulse after all %0d results", RESULTS);
                stop_on_error();
            end
            assert (done === 1'b0) else begin
                $display("ERR done: expected %h, got %h", 1'b0, done);
                stop_on_error();
            end
            assert (out_even === ref_c(2 * exp_pair, exp_col)) else begin
                $display("ERR out_even: expected %h, got %h",
                         ref_c(2 * exp_pair, exp_col), out_even);
                stop_on_error();
            end
            assert (out_odd === ref_c(2 * exp_pair + 1, exp_col)) else begin
                $display("ERR out_odd: expected %h, got %h",
                         ref_c(2 * exp_pair + 1, exp_col), out_odd);
                stop_on_error();
            end
            n_valid++;
            if (exp_col == mm_pkg::COLS_B - 1) begin  // Columns first, pairs after
                exp_col = 0;
                exp_pair++;
            end else begin
                exp_col++;
            end
        end else if (n_valid == RESULTS) begin
            assert (done === 1'b1) else begin
                $display("ERR done: expected %h, got %h", 1'b1, done);
                stop_on_error();
            end
        end else begin
            assert (done === 1'b0) else begin
                $display("ERR done: expected %h, got %h", 1'b0, done);
                stop_on_error();
            end
        end
    end

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        assert (done === 1'b0) else begin
            $display("ERR done: expected %h, got %h", 1'b0, done);
            stop_on_error();
        end
        assert (out_valid === 1'b0) else begin
            $display("ERR out_valid: expected %h, got %h", 1'b0, out_valid);
            stop_on_error();
        end
    endtask

    // Fresh matrices with A at -128 and B at -128 or 127 in extreme mode
    task automatic fill_matrices(input bit extreme);
        for (int r = 0; r < mm_pkg::ROWS_A; r++) begin
            for (int k = 0; k < mm_pkg::INNER; k++) begin
                a_mat[r][k] = extreme ? A_MIN : mm_pkg::a_elem_t'($random(seed));
            end
        end
        for (int k = 0; k < mm_pkg::INNER; k++) begin
            for (int c = 0; c < mm_pkg::COLS_B; c++) begin
                if (extreme) begin
                    b_mat[k][c] = (($random(seed) & 1) != 0) ? B_MAX : B_MIN;
                end else begin
                    b_mat[k][c] = mm_pkg::b_elem_t'($random(seed));
                end
            end
        end
    endtask

    // Writes A row-major and B column-major through both strobes at once
    task automatic load_memories();
        mm_pkg::in_word_t aw;
        mm_pkg::w_word_t  bw;
        for (int addr = 0; addr < LOAD_WORDS; addr++) begin
            @(posedge clk);
            #1;
            in_we = 1'b0;
            w_we  = 1'b0;
            if (addr < mm_pkg::IN_DEPTH) begin
                for (int e = 0; e < mm_pkg::CHUNK; e++) begin
                    aw[e] = a_mat[addr / mm_pkg::BLOCKS]
                                 [(addr % mm_pkg::BLOCKS) * mm_pkg::CHUNK + e];
                end
                in_we   = 1'b1;
                in_addr = mm_pkg::IN_ADDR_W'(addr);
                in_data = aw;
            end
            if (addr < mm_pkg::W_DEPTH) begin
                for (int e = 0; e < mm_pkg::CHUNK; e++) begin
                    bw[e] = b_mat[(addr % mm_pkg::BLOCKS) * mm_pkg::CHUNK + e]
                                 [addr / mm_pkg::BLOCKS];
                end
                w_we   = 1'b1;
                w_addr = mm_pkg::W_ADDR_W'(addr);
                w_data = bw;
            end
        end
        @(posedge clk);
        #1;
        in_we = 1'b0;
        w_we  = 1'b0;
    endtask

    // One full load, compute and idle pass
    task automatic run_matrix(input bit extreme, input bit junk_writes);
        fill_matrices(extreme);
        load_memories();
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        while (done !== 1'b1) begin  // Runs until done
            @(posedge clk);
            #1;
            if (junk_writes) begin  // Must be ignored outside load
                in_we   = 1'b1;
                in_addr = mm_pkg::IN_ADDR_W'($random(seed));
                in_data = mm_pkg::in_word_t'($random(seed));
                w_we    = 1'b1;
                w_addr  = mm_pkg::W_ADDR_W'($random(seed));
                w_data  = mm_pkg::w_word_t'($random(seed));
                start   = 1'b1;
            end
        end
        in_we = 1'b0;
        w_we  = 1'b0;
        start = 1'b0;
        repeat (IDLE_CYCLES) begin  // done stays high with no more pulses
            @(posedge clk);
            #1;
            assert (done === 1'b1) else begin
                $display("ERR done: expected %h, got %h", 1'b1, done);
                stop_on_error();
            end
        end
        assert (n_valid == RESULTS) else begin
            $display("ERR n_valid: expected %h, got %h", RESULTS, n_valid);
            stop_on_error();
        end
    endtask

    initial begin
        rst_n   = 1'b0;
        start   = 1'b0;
        in_we   = 1'b0;
        in_addr = '0;
        in_data = '0;
        w_we    = 1'b0;
        w_addr  = '0;
        w_data  = '0;
        apply_reset();
        run_matrix(1'b0, 1'b1);  // Random data with writes during compute
        apply_reset();
        run_matrix(1'b1, 1'b0);  // Extreme values
        apply_reset();
        run_matrix(1'b0, 1'b0);  // Fresh data after reset
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/mm_top.sv
// Top level: input and weight memories, sequencer,
// even-row and odd-row dot-product accumulators
`timescale 1ns/100ps
`default_nettype none

module mm_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  logic                         in_we,
    input  logic [mm_pkg::IN_ADDR_W-1:0] in_addr,
    input  mm_pkg::in_word_t             in_data,
    input  logic                         w_we,
    input  logic [mm_pkg::W_ADDR_W-1:0]  w_addr,
    input  mm_pkg::w_word_t              w_data,
    output logic                         out_valid,
    output mm_pkg::acc_t                 out_even,  // C[2*pair][col]
    output mm_pkg::acc_t                 out_odd,   // C[2*pair+1][col]
    output logic                         done
);

    logic blk_valid;
    logic blk_first;
    logic blk_last;
    logic res_valid;  // Even lane, odd lane runs in lockstep

    // Memory ports
    ram_port_if #(.word_t(mm_pkg::in_word_t), .ADDR_W(mm_pkg::IN_ADDR_W)) in_pa ();
    ram_port_if #(.word_t(mm_pkg::in_word_t), .ADDR_W(mm_pkg::IN_ADDR_W)) in_pb ();
    ram_port_if #(.word_t(mm_pkg::w_word_t),  .ADDR_W(mm_pkg::W_ADDR_W))  w_pa ();
    ram_port_if #(.word_t(mm_pkg::w_word_t),  .ADDR_W(mm_pkg::W_ADDR_W))  w_pb ();

    // A, row-major
    tdp_ram #(
        .word_t(mm_pkg::in_word_t),
        .DEPTH (mm_pkg::IN_DEPTH),
        .ADDR_W(mm_pkg::IN_ADDR_W)
    ) u_in_ram (
        .clk   (clk),
        .port_a(in_pa),
        .port_b(in_pb)
    );

    // B, column-major
    tdp_ram #(
        .word_t(mm_pkg::w_word_t),
        .DEPTH (mm_pkg::W_DEPTH),
        .ADDR_W(mm_pkg::W_ADDR_W)
    ) u_w_ram (
        .clk   (clk),
        .port_a(w_pa),
        .port_b(w_pb)
    );

    mm_sequencer u_seq (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .in_we    (in_we),
        .in_addr  (in_addr),
        .in_data  (in_data),
        .w_we     (w_we),
        .w_addr   (w_addr),
        .w_data   (w_data),
        .res_valid(res_valid),
        .in_pa    (in_pa),
        .in_pb    (in_pb),
        .w_pa     (w_pa),
        .w_pb     (w_pb),
        .blk_valid(blk_valid),
        .blk_first(blk_first),
        .blk_last (blk_last),
        .done     (done)
    );

    // Even row lane
    dot_accumulator #(.a_t(mm_pkg::in_word_t), .b_t(mm_pkg::w_word_t)) u_acc_even (
        .clk      (clk),
        .rst_n    (rst_n),
        .a_word   (in_pa.dout),
        .b_word   (w_pb.dout),
        .blk_valid(blk_valid),
        .blk_first(blk_first),
        .blk_last (blk_last),
        .res      (out_even),
        .res_valid(res_valid)
    );

    // Odd row lane, same tags so its valid is redundant
    dot_accumulator #(.a_t(mm_pkg::in_word_t), .b_t(mm_pkg::w_word_t)) u_acc_odd (
        .clk      (clk),
        .rst_n    (rst_n),
        .a_word   (in_pb.dout),
        .b_word   (w_pb.dout),
        .blk_valid(blk_valid),
        .blk_first(blk_first),
        .blk_last (blk_last),
        .res      (out_odd),
        .res_valid()
    );

    assign out_valid = res_valid;

endmodule

`default_nettype wire

//--- rtl/dot_accumulator.sv
// Chunked dot product: registered products, adder tree,
// accumulation over the inner dimension
`timescale 1ns/100ps
`default_nettype none

module dot_accumulator #(
    parameter type a_t = mm_pkg::in_word_t,  // Word of CHUNK signed elements
    parameter type b_t = mm_pkg::w_word_t
) (
    input  logic         clk,
    input  logic         rst_n,
    input  a_t           a_word,
    input  b_t           b_word,
    input  logic         blk_valid,
    input  logic         blk_first,  // Load instead of add
    input  logic         blk_last,   // Present total after this block
    output mm_pkg::acc_t res,
    output logic         res_valid
);

    localparam int CHUNK  = mm_pkg::CHUNK;
    localparam int PROD_W = $bits(a_t) / CHUNK + $bits(b_t) / CHUNK;

    logic signed [PROD_W-1:0] prod_q [CHUNK];  // Stage one products
    logic                     valid_q;
    logic                     first_q;
    logic                     last_q;
    mm_pkg::acc_t             blk_sum;         // Tree output
    mm_pkg::acc_t             acc_q;

    // Stage one, element-wise signed products
    always_ff @(posedge clk) begin
        for (int i = 0; i < CHUNK; i++) begin
            prod_q[i] <= a_word[i] * b_word[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            first_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            valid_q <= blk_valid;
            first_q <= blk_first;
            last_q  <= blk_last;
        end
    end

    // Heap-ordered tree: leaves at CHUNK..2*CHUNK-1, root at 1
    always_comb begin
        mm_pkg::acc_t node [1:2*CHUNK-1];
        for (int i = 0; i < CHUNK; i++) begin
            node[CHUNK + i] = mm_pkg::acc_t'(prod_q[i]);  // Sign extend
        end
        for (int n = CHUNK - 1; n >= 1; n--) begin
            node[n] = node[2 * n] + node[2 * n + 1];
        end
        blk_sum = node[1];
    end

    // Stage two, running sum across blocks
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc_q     <= '0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= valid_q & last_q;  // One pulse per element
            if (valid_q) begin
                acc_q <= first_q ? blk_sum : acc_q + blk_sum;
            end
        end
    end

    assign res = acc_q;  // Total is final when res_valid is high

endmodule

`default_nettype wire

//--- rtl/mm_sequencer.sv
// Phase control, RAM port multiplexing, chunked read address stepping,
// block tags and the sticky done flag
`timescale 1ns/100ps
`default_nettype none

module mm_sequencer (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start,      // Ends the load phase
    // External write strobes, load phase only
    input  logic                           in_we,
    input  logic [mm_pkg::IN_ADDR_W-1:0]   in_addr,
    input  mm_pkg::in_word_t               in_data,
    input  logic                           w_we,
    input  logic [mm_pkg::W_ADDR_W-1:0]    w_addr,
    input  mm_pkg::w_word_t                w_data,
    input  logic                           res_valid,  // From even accumulator
    ram_port_if.ctrl                       in_pa,      // Even rows, also load port
    ram_port_if.ctrl                       in_pb,      // Odd rows
    ram_port_if.ctrl                       w_pa,       // Weight load port
    ram_port_if.ctrl                       w_pb,       // Weight read port
    output logic                           blk_valid,  // Tags aligned with RAM dout
    output logic                           blk_first,
    output logic                           blk_last,
    output logic                           done
);

    localparam int PAIRS   = mm_pkg::ROWS_A / 2;
    localparam int RESULTS = PAIRS * mm_pkg::COLS_B;  // res_valid pulses per run
    localparam int BLK_W   = (mm_pkg::BLOCKS > 1) ? $clog2(mm_pkg::BLOCKS) : 1;
    localparam int COL_W   = (mm_pkg::COLS_B > 1) ? $clog2(mm_pkg::COLS_B) : 1;
    localparam int PAIR_W  = (PAIRS > 1) ? $clog2(PAIRS) : 1;
    localparam int RES_W   = $clog2(RESULTS + 1);

    logic              load_phase;  // High from reset until start
    logic              issue_done;  // All reads issued
    logic              issuing;     // A read goes out this cycle
    logic [BLK_W-1:0]  blk_cnt;     // Chunk along the inner dimension
    logic [COL_W-1:0]  col_cnt;     // Column of B and C
    logic [PAIR_W-1:0] pair_cnt;    // Row pair of A and C
    logic [RES_W-1:0]  res_cnt;
    logic              blk_is_last;

    logic [mm_pkg::IN_ADDR_W-1:0] rd_addr_even;
    logic [mm_pkg::IN_ADDR_W-1:0] rd_addr_odd;
    logic [mm_pkg::W_ADDR_W-1:0]  rd_addr_w;

    assign issuing     = ~load_phase & ~issue_done;
    assign blk_is_last = (blk_cnt == BLK_W'(mm_pkg::BLOCKS - 1));

    // Row 2*pair on port A, row 2*pair+1 on port B
    assign rd_addr_even = mm_pkg::IN_ADDR_W'((2 * pair_cnt) * mm_pkg::BLOCKS + blk_cnt);
    assign rd_addr_odd  = mm_pkg::IN_ADDR_W'((2 * pair_cnt + 1) * mm_pkg::BLOCKS + blk_cnt);
    assign rd_addr_w    = mm_pkg::W_ADDR_W'(col_cnt * mm_pkg::BLOCKS + blk_cnt);

    // Input RAM port A: external writes in load, even-row reads in compute
    assign in_pa.en   = load_phase ? in_we : issuing;
    assign in_pa.we   = load_phase & in_we;
    assign in_pa.addr = load_phase ? in_addr : rd_addr_even;
    assign in_pa.din  = in_data;

    // Input RAM port B, read only
    assign in_pb.en   = issuing;
    assign in_pb.we   = 1'b0;
    assign in_pb.addr = rd_addr_odd;
    assign in_pb.din  = '0;

    // Weight RAM port A, write only
    assign w_pa.en   = load_phase & w_we;
    assign w_pa.we   = load_phase & w_we;
    assign w_pa.addr = w_addr;
    assign w_pa.din  = w_data;

    // Weight RAM port B, column reads
    assign w_pb.en   = issuing;
    assign w_pb.we   = 1'b0;
    assign w_pb.addr = rd_addr_w;
    assign w_pb.din  = '0;

    // Phase flag and block/column/pair stepping
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            load_phase <= 1'b1;
            issue_done <= 1'b0;
            blk_cnt    <= '0;
            col_cnt    <= '0;
            pair_cnt   <= '0;
        end else begin
            if (load_phase && start) begin
                load_phase <= 1'b0;  // First read on the next edge
            end
            if (issuing) begin
                if (blk_is_last) begin
                    blk_cnt <= '0;
                    if (col_cnt == COL_W'(mm_pkg::COLS_B - 1)) begin
                        col_cnt <= '0;
                        if (pair_cnt == PAIR_W'(PAIRS - 1)) begin
                            pair_cnt   <= '0;
                            issue_done <= 1'b1;  // Last read just went out
                        end else begin
                            pair_cnt <= pair_cnt + 1'b1;
                        end
                    end else begin
                        col_cnt <= col_cnt + 1'b1;
                    end
                end else begin
                    blk_cnt <= blk_cnt + 1'b1;
                end
            end
        end
    end

    // Tags follow the read by one cycle, same as RAM dout
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            blk_valid <= 1'b0;
            blk_first <= 1'b0;
            blk_last  <= 1'b0;
        end else begin
            blk_valid <= issuing;
            blk_first <= issuing & (blk_cnt == '0);
            blk_last  <= issuing & blk_is_last;
        end
    end

    // Result count, done sticks until reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_cnt <= '0;
            done    <= 1'b0;
        end else if (res_valid && !done) begin
            res_cnt <= res_cnt + 1'b1;
            if (res_cnt == RES_W'(RESULTS - 1)) begin
                done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/tdp_ram.sv
// Behavioral true-dual-port RAM, one-cycle read latency, write-first per port
`timescale 1ns/100ps
`default_nettype none

module tdp_ram #(
    parameter type word_t = logic [31:0],
    parameter int  DEPTH  = 8,
    parameter int  ADDR_W = 3
) (
    input  logic   clk,
    ram_port_if.mem port_a,
    ram_port_if.mem port_b
);

    word_t mem [DEPTH];  // Word storage

    logic [ADDR_W-1:0] addr_a;
    logic [ADDR_W-1:0] addr_b;

    assign addr_a = port_a.addr;
    assign addr_b = port_b.addr;

    // Write-first on each port with registered read data
    // Port B wins when both ports write one address
    always_ff @(posedge clk) begin
        if (port_a.en) begin
            if (port_a.we) begin
                mem[addr_a] <= port_a.din;
                port_a.dout <= port_a.din;  // Write-first
            end else begin
                port_a.dout <= mem[addr_a];
            end
        end
        if (port_b.en) begin
            if (port_b.we) begin
                mem[addr_b] <= port_b.din;
                port_b.dout <= port_b.din;  // Write-first
            end else begin
                port_b.dout <= mem[addr_b];
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/ram_port_if.sv
// One RAM port: enable, write enable, address, write data, read data
`timescale 1ns/100ps
`default_nettype none

interface ram_port_if #(
    parameter type word_t = logic [31:0],  // Memory word
    parameter int  ADDR_W = 3
) ();

    logic              en;    // Port enable, read or write
    logic              we;    // Write when en also high
    logic [ADDR_W-1:0] addr;
    word_t             din;
    word_t             dout;  // Valid one cycle after a read

    // Controller side
    modport ctrl (output en, output we, output addr, output din, input dout);

    // Memory side
    modport mem (input en, input we, input addr, input din, output dout);

endinterface

`default_nettype wire

//--- rtl/mm_pkg.sv
// Matrix dimensions, element widths and memory word types
// shared by the matrix-multiply engine
`default_nettype none

package mm_pkg;

    // Matrix shape, C = A x B
    localparam int ROWS_A = 4;  // Rows of A, must be even
    localparam int COLS_B = 4;  // Columns of B and of C
    localparam int INNER  = 8;  // Shared inner dimension

    // Memory word packing
    localparam int CHUNK  = 4;              // Elements per word
    localparam int BLOCKS = INNER / CHUNK;  // Words per row or column

    // Element widths, all signed
    localparam int WIDTH_A   = 8;
    localparam int WIDTH_B   = 8;
    localparam int WIDTH_OUT = 24;

    // Memory geometry
    localparam int IN_DEPTH  = ROWS_A * BLOCKS;  // A stored row-major
    localparam int W_DEPTH   = COLS_B * BLOCKS;  // B stored column-major
    localparam int IN_ADDR_W = $clog2(IN_DEPTH);
    localparam int W_ADDR_W  = $clog2(W_DEPTH);

    // Single elements
    typedef logic signed [WIDTH_A-1:0] a_elem_t;
    typedef logic signed [WIDTH_B-1:0] b_elem_t;

    // Element 0 sits in the low bits of a word
    typedef a_elem_t [CHUNK-1:0] in_word_t;
    typedef b_elem_t [CHUNK-1:0] w_word_t;

    // One element of C
    typedef logic signed [WIDTH_OUT-1:0] acc_t;

endpackage

`default_nettype wire
